//--- regs_cfg.svh
`ifndef REGS_CFG_SVH
`define REGS_CFG_SVH

// Width of one data word in the register files.
`define REGS_DATA_W 32

// General-purpose register file geometry.
`define REGS_GPR_N  32
`define REGS_GPR_AW 5

// Control register file geometry.
`define REGS_CREG_N  8
`define REGS_CREG_AW 3

// External interrupt lines, accumulated into the low bits of creg_pend.
`define REGS_IRQ_N 16

// The compiler places function return values in r3.
`define REGS_RET_REG 3

`endif

//--- regs_pkg.sv
`default_nettype none

`include "regs_cfg.svh"

package regs_pkg;

  typedef logic [`REGS_DATA_W-1:0]  word_t;      // One data word.
  typedef logic [`REGS_GPR_AW-1:0]  gpr_addr_t;  // General-purpose register index.
  typedef logic [`REGS_CREG_AW-1:0] creg_addr_t; // Control register index.
  typedef logic [`REGS_IRQ_N-1:0]   irq_vec_t;   // One bit per interrupt line.

  // Control register map. A nonzero creg_mode means kernel mode, and bit 31
  // of creg_mask is the global interrupt enable.
  typedef enum creg_addr_t {
    creg_mode = 3'd0,
    creg_rsvd = 3'd1,
    creg_pend = 3'd2,
    creg_mask = 3'd3,
    creg_epc  = 3'd4,
    creg_efg  = 3'd5,
    creg_cdv  = 3'd6,
    creg_tlb  = 3'd7
  } creg_e;

endpackage

`default_nettype wire

//--- regs_if.sv
`timescale 1ns/1ps
`default_nettype none

// Resolved general-purpose write ports. By the time writes reach this bundle
// neither port targets r0 and port 1 never collides with an enabled port 0.
interface gpr_wr_if;

  logic                 wen0;
  regs_pkg::gpr_addr_t  waddr0;
  regs_pkg::word_t      wdata0;
  logic                 wen1;
  regs_pkg::gpr_addr_t  waddr1;
  regs_pkg::word_t      wdata1;

  modport src (
    output wen0,
    output waddr0,
    output wdata0,
    output wen1,
    output waddr1,
    output wdata1
  );

  modport dst (
    input wen0,
    input waddr0,
    input wdata0,
    input wen1,
    input waddr1,
    input wdata1
  );

endinterface

`default_nettype wire

//--- write_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module write_arbiter (
  input  logic                wen0,
  input  regs_pkg::gpr_addr_t waddr0,
  input  regs_pkg::word_t     wdata0,
  input  logic                wen1,
  input  regs_pkg::gpr_addr_t waddr1,
  input  regs_pkg::word_t     wdata1,
  input  logic                cwen,
  input  regs_pkg::creg_e     cwaddr,
  input  regs_pkg::word_t     cwdata,
  input  logic                kmode,
  gpr_wr_if.src               wr,
  output logic                creg_wen,
  output regs_pkg::creg_e     creg_waddr,
  output regs_pkg::word_t     creg_wdata,
  output logic                priv_violation
);

  logic port0_is_r0;
  logic port1_is_r0;
  logic port_clash;

  assign port0_is_r0 = (waddr0 == '0);
  assign port1_is_r0 = (waddr1 == '0);

  // Port 0 carries load data, so it wins when both ports hit one register.
  assign port_clash = wen0 && (waddr0 == waddr1);

  assign wr.wen0   = wen0 && !port0_is_r0; // r0 is hardwired to zero.
  assign wr.waddr0 = waddr0;
  assign wr.wdata0 = wdata0;

  // Port 1 serves pre and post increment address updates.
  assign wr.wen1   = wen1 && !port1_is_r0 && !port_clash;
  assign wr.waddr1 = waddr1;
  assign wr.wdata1 = wdata1;

  // Control registers are writable only from kernel mode.
  assign creg_wen   = cwen && kmode;
  assign creg_waddr = cwaddr;
  assign creg_wdata = cwdata;

  assign priv_violation = cwen && !kmode; // Refused write, reported in the same cycle.

endmodule

`default_nettype wire

//--- gpr_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "regs_cfg.svh"

module gpr_file (
  input  logic                clk,
  input  logic                rst_n,
  gpr_wr_if.dst               wr,
  input  regs_pkg::gpr_addr_t raddr0,
  input  regs_pkg::gpr_addr_t raddr1,
  input  logic                stall,
  output regs_pkg::word_t     rdata0,
  output regs_pkg::word_t     rdata1,
  output regs_pkg::word_t     ret_val
);

  regs_pkg::word_t mem [`REGS_GPR_N];

  // Both write ports land at the same edge. The arbiter guarantees that they
  // never address the same entry, so their order here does not matter.
  always_ff @(posedge clk) begin
    if (wr.wen0) begin
      mem[wr.waddr0] <= wr.wdata0;
    end
    if (wr.wen1) begin
      mem[wr.waddr1] <= wr.wdata1;
    end
  end

  // Registered reads. There is no bypass, so a read that coincides with a
  // write to the same register sees the old contents.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata0 <= '0;
      rdata1 <= '0;
    end else if (!stall) begin
      rdata0 <= (raddr0 == '0) ? '0 : mem[raddr0]; // r0 always reads zero.
      rdata1 <= (raddr1 == '0) ? '0 : mem[raddr1];
    end
  end

  // The return-value register is tapped directly for observation.
  assign ret_val = mem[`REGS_RET_REG];

endmodule

`default_nettype wire

//--- creg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "regs_cfg.svh"

module creg_file (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               creg_wen,
  input  regs_pkg::creg_e    creg_waddr,
  input  regs_pkg::word_t    creg_wdata,
  input  regs_pkg::creg_e    craddr,
  input  logic               stall,
  input  logic               exc,
  input  logic               tlb_exc,
  input  regs_pkg::word_t    tlb_addr,
  input  regs_pkg::word_t    epc,
  input  regs_pkg::word_t    efg,
  input  regs_pkg::irq_vec_t interrupts,
  output regs_pkg::word_t    crdata,
  output logic               kmode,
  output regs_pkg::word_t    cdv_out,
  output regs_pkg::word_t    pend,
  output regs_pkg::word_t    mask
);

  regs_pkg::word_t cregs [`REGS_CREG_N];
  regs_pkg::word_t irq_word;

  // Interrupt lines occupy the low bits of the pending register.
  assign irq_word = regs_pkg::word_t'(interrupts);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `REGS_CREG_N; i++) begin
        cregs[i] <= '0;
      end
      cregs[regs_pkg::creg_mode] <= regs_pkg::word_t'(1); // Come up in kernel mode.
      crdata <= '0;
    end else begin
      if (!stall) begin
        if (!exc) begin
          crdata <= cregs[craddr];
        end else begin
          // An exception freezes the read port and records where and why.
          cregs[regs_pkg::creg_epc] <= epc;
          cregs[regs_pkg::creg_efg] <= efg;
          if (tlb_exc) begin
            cregs[regs_pkg::creg_tlb] <= tlb_addr; // Faulting translation address.
          end
        end

        // Lines stay pending until software clears them.
        cregs[regs_pkg::creg_pend] <= cregs[regs_pkg::creg_pend] | irq_word;
      end

      // Software writes are placed last so that they override any hardware
      // update of the same register at this edge.
      if (creg_wen) begin
        cregs[creg_waddr] <= creg_wdata;
      end
    end
  end

  assign kmode   = (cregs[regs_pkg::creg_mode] != '0);
  assign cdv_out = cregs[regs_pkg::creg_cdv];
  assign pend    = cregs[regs_pkg::creg_pend];
  assign mask    = cregs[regs_pkg::creg_mask];

endmodule

`default_nettype wire

//--- irq_status.sv
`timescale 1ns/1ps
`default_nettype none

`include "regs_cfg.svh"

module irq_status (
  input  regs_pkg::word_t                 pend,
  input  regs_pkg::word_t                 mask,
  output regs_pkg::word_t                 interrupt_state,
  output logic                            irq_valid,
  output logic [$clog2(`REGS_IRQ_N)-1:0]  irq_line
);

  localparam int LINE_W = $clog2(`REGS_IRQ_N);

  logic               global_en;
  regs_pkg::irq_vec_t active;

  assign global_en = mask[`REGS_DATA_W-1]; // Top bit of the mask is the master enable.

  assign interrupt_state = global_en ? (pend & mask) : '0;

  // Only the external line bits take part in line selection.
  assign active    = interrupt_state[`REGS_IRQ_N-1:0];
  assign irq_valid = |active;

  // Lowest numbered line has the highest priority. Scanning downward lets the
  // last match, which is the lowest set bit, win.
  always_comb begin
    irq_line = '0;
    for (int i = `REGS_IRQ_N - 1; i >= 0; i--) begin
      if (active[i]) begin
        irq_line = LINE_W'(i);
      end
    end
  end

endmodule

`default_nettype wire

//--- regs_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "regs_cfg.svh"

module regs_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           stall,
  input  logic                           wen0,
  input  regs_pkg::gpr_addr_t            waddr0,
  input  regs_pkg::word_t                wdata0,
  input  logic                           wen1,
  input  regs_pkg::gpr_addr_t            waddr1,
  input  regs_pkg::word_t                wdata1,
  input  regs_pkg::gpr_addr_t            raddr0,
  input  regs_pkg::gpr_addr_t            raddr1,
  input  logic                           cwen,
  input  regs_pkg::creg_e                cwaddr,
  input  regs_pkg::word_t                cwdata,
  input  regs_pkg::creg_e                craddr,
  input  logic                           exc,
  input  logic                           tlb_exc,
  input  regs_pkg::word_t                tlb_addr,
  input  regs_pkg::word_t                epc,
  input  regs_pkg::word_t                efg,
  input  regs_pkg::irq_vec_t             interrupts,
  output regs_pkg::word_t                rdata0,
  output regs_pkg::word_t                rdata1,
  output regs_pkg::word_t                ret_val,
  output regs_pkg::word_t                crdata,
  output logic                           kmode,
  output regs_pkg::word_t                cdv_out,
  output regs_pkg::word_t                interrupt_state,
  output logic                           irq_valid,
  output logic [$clog2(`REGS_IRQ_N)-1:0] irq_line,
  output logic                           priv_violation
);

  gpr_wr_if gpr_wr ();

  logic            creg_wen;
  regs_pkg::creg_e creg_waddr;
  regs_pkg::word_t creg_wdata;
  regs_pkg::word_t pend;
  regs_pkg::word_t mask;

  write_arbiter i_write_arbiter (
    .wen0           (wen0),
    .waddr0         (waddr0),
    .wdata0         (wdata0),
    .wen1           (wen1),
    .waddr1         (waddr1),
    .wdata1         (wdata1),
    .cwen           (cwen),
    .cwaddr         (cwaddr),
    .cwdata         (cwdata),
    .kmode          (kmode),      // Privilege comes back from the control registers.
    .wr             (gpr_wr.src),
    .creg_wen       (creg_wen),
    .creg_waddr     (creg_waddr),
    .creg_wdata     (creg_wdata),
    .priv_violation (priv_violation)
  );

  gpr_file i_gpr_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr      (gpr_wr.dst),
    .raddr0  (raddr0),
    .raddr1  (raddr1),
    .stall   (stall),
    .rdata0  (rdata0),
    .rdata1  (rdata1),
    .ret_val (ret_val)
  );

  creg_file i_creg_file (
    .clk        (clk),
    .rst_n      (rst_n),
    .creg_wen   (creg_wen),
    .creg_waddr (creg_waddr),
    .creg_wdata (creg_wdata),
    .craddr     (craddr),
    .stall      (stall),
    .exc        (exc),
    .tlb_exc    (tlb_exc),
    .tlb_addr   (tlb_addr),
    .epc        (epc),
    .efg        (efg),
    .interrupts (interrupts),
    .crdata     (crdata),
    .kmode      (kmode),
    .cdv_out    (cdv_out),
    .pend       (pend),
    .mask       (mask)
  );

  irq_status i_irq_status (
    .pend            (pend),
    .mask            (mask),
    .interrupt_state (interrupt_state),
    .irq_valid       (irq_valid),
    .irq_line        (irq_line)
  );

endmodule

`default_nettype wire

//--- regs_tb_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module regs_assertions (
  input logic            clk,
  input logic            rst_n,
  input logic            stall,
  input logic            exc,
  input logic            cwen,
  input logic            kmode,
  input logic            priv_violation,
  input logic            irq_valid,
  input regs_pkg::word_t mask,
  input regs_pkg::word_t crdata
);

  // A refused control write can only come from user mode.
  a_priv_source: assert property (@(posedge clk) disable iff (!rst_n)
    priv_violation |-> (cwen && !kmode))
    else $error("priv_violation raised without a user-mode control write");

  a_irq_enabled: assert property (@(posedge clk) disable iff (!rst_n)
    irq_valid |-> mask[31]) // Global enable gates every line.
    else $error("irq_valid raised while interrupts are globally disabled");

  // The control read port freezes on stall and on exceptions.
  a_crdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (stall || exc) |=> $stable(crdata))
    else $error("crdata changed across an edge with stall or exc high");

endmodule

bind regs_top regs_assertions i_regs_assertions (
  .clk            (clk),
  .rst_n          (rst_n),
  .stall          (stall),
  .exc            (exc),
  .cwen           (cwen),
  .kmode          (kmode),
  .priv_violation (priv_violation),
  .irq_valid      (irq_valid),
  .mask           (mask),
  .crdata         (crdata)
);

`default_nettype wire

//--- regs_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "regs_cfg.svh"

module regs_tb;

  localparam int CLK_PERIOD = 4;
  localparam int LINE_W     = $clog2(`REGS_IRQ_N);

  typedef enum logic [1:0] {exp_skip, exp_fixed, exp_model} exp_e;

  // One table row holds the inputs for one cycle and what to expect after the edge.
  typedef struct packed {
    logic                stall, wen0, wen1, cwen, exc, tlb_exc;
    regs_pkg::gpr_addr_t waddr0, waddr1, raddr0, raddr1;
    regs_pkg::word_t     wdata0, wdata1, cwdata, tlb_addr, epc, efg;
    regs_pkg::creg_e     cwaddr, craddr;
    regs_pkg::irq_vec_t  interrupts;
    exp_e                rd_exp, cr_exp;
    regs_pkg::word_t     exp_rd0, exp_rd1, exp_cr;
  } row_t;

  logic                clk, rst_n, stall, wen0, wen1, cwen, exc, tlb_exc;
  regs_pkg::gpr_addr_t waddr0, waddr1, raddr0, raddr1;
  regs_pkg::word_t     wdata0, wdata1, cwdata, tlb_addr, epc, efg;
  regs_pkg::creg_e     cwaddr, craddr;
  regs_pkg::irq_vec_t  interrupts;
  regs_pkg::word_t     rdata0, rdata1, ret_val, crdata, cdv_out, interrupt_state;
  logic                kmode, irq_valid, priv_violation;
  logic [LINE_W-1:0]   irq_line;

  row_t                rows[$];
  string               names[$];
  logic                table_built;
  logic [31:0]         rng_state;
  regs_pkg::word_t     m_gpr [`REGS_GPR_N];     // Reference copy of the register array.
  logic                gpr_known [`REGS_GPR_N];
  regs_pkg::word_t     m_cr [`REGS_CREG_N];
  regs_pkg::word_t     m_rd0, m_rd1, m_crd;

  regs_top i_dut (.*);

  function automatic regs_pkg::word_t next_rand();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  function automatic row_t idle_row();
    row_t r;
    r = '0;
    r.rd_exp = exp_model;
    r.cr_exp = exp_model;
    r.craddr = regs_pkg::creg_mode;
    return r;
  endfunction

  function automatic row_t gpr_write(regs_pkg::gpr_addr_t a, regs_pkg::word_t d);
    row_t r;
    r = idle_row();
    r.wen0 = 1'b1;
    r.waddr0 = a;
    r.wdata0 = d;
    return r;
  endfunction

  function automatic row_t gpr_read(regs_pkg::gpr_addr_t a0, regs_pkg::gpr_addr_t a1);
    row_t r;
    r = idle_row();
    r.raddr0 = a0;
    r.raddr1 = a1;
    return r;
  endfunction

  function automatic row_t creg_write(regs_pkg::creg_e a, regs_pkg::word_t d);
    row_t r;
    r = idle_row();
    r.cwen = 1'b1;
    r.cwaddr = a;
    r.cwdata = d;
    return r;
  endfunction

  function automatic row_t creg_read(regs_pkg::creg_e a);
    row_t r;
    r = idle_row();
    r.craddr = a;
    return r;
  endfunction

  task automatic add_row(string name, row_t r);
    names.push_back(name);
    rows.push_back(r);
  endtask

  task automatic abort_run(string why);
    $display("Test failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_word(string test, string what, regs_pkg::word_t exp,
                            regs_pkg::word_t act);
    if (act !== exp) begin
      $display("error %s %s: expected %h, actual %h", test, what, exp, act);
      abort_run("Stopped at the first mismatching word.");
    end
  endtask

  task automatic check_bit(string test, string what, logic exp, logic act);
    if (act !== exp) begin
      $display("error %s %s: expected %b, actual %b", test, what, exp, act);
      abort_run("Stopped at the first mismatching flag.");
    end
  endtask

  task automatic check_line(string test, logic [LINE_W-1:0] exp, logic [LINE_W-1:0] act);
    if (act !== exp) begin
      $display("error %s irq_line: expected %0d, actual %0d", test, exp, act);
      abort_run("Stopped at the first mismatching interrupt line.");
    end
  endtask

  task automatic drive_row(row_t r);
    stall = r.stall;
    wen0 = r.wen0;
    waddr0 = r.waddr0;
    wdata0 = r.wdata0;
    wen1 = r.wen1;
    waddr1 = r.waddr1;
    wdata1 = r.wdata1;
    raddr0 = r.raddr0;
    raddr1 = r.raddr1;
    cwen = r.cwen;
    cwaddr = r.cwaddr;
    cwdata = r.cwdata;
    craddr = r.craddr;
    exc = r.exc;
    tlb_exc = r.tlb_exc;
    tlb_addr = r.tlb_addr;
    epc = r.epc;
    efg = r.efg;
    interrupts = r.interrupts;
  endtask

  // Advances the model by one rising edge. Reads use the state from before the edge.
  task automatic model_step(row_t r);
    logic kernel;
    kernel = (m_cr[regs_pkg::creg_mode] != '0);
    if (!r.stall) begin
      m_rd0 = (r.raddr0 == '0) ? '0 : m_gpr[r.raddr0];
      m_rd1 = (r.raddr1 == '0) ? '0 : m_gpr[r.raddr1];
      if (!r.exc) begin
        m_crd = m_cr[r.craddr];
      end else begin
        m_cr[regs_pkg::creg_epc] = r.epc;
        m_cr[regs_pkg::creg_efg] = r.efg;
        if (r.tlb_exc) begin
          m_cr[regs_pkg::creg_tlb] = r.tlb_addr;
        end
      end
      m_cr[regs_pkg::creg_pend] |= regs_pkg::word_t'(r.interrupts);
    end
    if (r.cwen && kernel) begin
      m_cr[r.cwaddr] = r.cwdata; // Software beats the hardware update.
    end
    if (r.wen1 && r.waddr1 != '0 && !(r.wen0 && r.waddr0 == r.waddr1)) begin
      m_gpr[r.waddr1] = r.wdata1;
      gpr_known[r.waddr1] = 1'b1;
    end
    if (r.wen0 && r.waddr0 != '0) begin
      m_gpr[r.waddr0] = r.wdata0;
      gpr_known[r.waddr0] = 1'b1;
    end
  endtask

  task automatic check_row(int idx);
    row_t              r;
    string             n;
    regs_pkg::word_t   st;
    logic              valid;
    logic [LINE_W-1:0] line;
    r = rows[idx];
    n = names[idx];
    if (r.rd_exp == exp_fixed) begin
      check_word(n, "rdata0", r.exp_rd0, rdata0);
      check_word(n, "rdata1", r.exp_rd1, rdata1);
    end else if (r.rd_exp == exp_model) begin
      check_word(n, "rdata0", m_rd0, rdata0);
      check_word(n, "rdata1", m_rd1, rdata1);
    end
    if (r.cr_exp == exp_fixed) begin
      check_word(n, "crdata", r.exp_cr, crdata);
    end else if (r.cr_exp == exp_model) begin
      check_word(n, "crdata", m_crd, crdata);
    end
    if (gpr_known[`REGS_RET_REG]) begin
      check_word(n, "ret_val", m_gpr[`REGS_RET_REG], ret_val);
    end
    check_bit(n, "kmode", m_cr[regs_pkg::creg_mode] != '0, kmode);
    check_bit(n, "priv_violation", r.cwen && (m_cr[regs_pkg::creg_mode] == '0),
              priv_violation);
    check_word(n, "cdv_out", m_cr[regs_pkg::creg_cdv], cdv_out);
    // The lowest set external line of the masked pending word is the expected line.
    st = m_cr[regs_pkg::creg_mask][`REGS_DATA_W-1] ?
         (m_cr[regs_pkg::creg_pend] & m_cr[regs_pkg::creg_mask]) : '0;
    valid = 1'b0;
    line = '0;
    for (int i = 0; i < `REGS_IRQ_N; i++) begin
      if (st[i] && !valid) begin
        valid = 1'b1;
        line = LINE_W'(i);
      end
    end
    check_word(n, "interrupt_state", st, interrupt_state);
    check_bit(n, "irq_valid", valid, irq_valid);
    check_line(n, line, irq_line);
  endtask

  task automatic build_table();
    row_t            r;
    regs_pkg::word_t a;
    regs_pkg::word_t b;
    r = gpr_read('0, '0);
    r.rd_exp = exp_fixed;
    r.cr_exp = exp_fixed;
    r.exp_cr = regs_pkg::word_t'(1); // The block leaves reset in kernel mode.
    add_row("reset_state", r);
    for (int i = 0; i < `REGS_GPR_N; i++) begin
      add_row("write_all", gpr_write(regs_pkg::gpr_addr_t'(i), next_rand()));
    end
    for (int i = 0; i < `REGS_GPR_N; i++) begin
      add_row("read_all", gpr_read(regs_pkg::gpr_addr_t'(i),
                                   regs_pkg::gpr_addr_t'(`REGS_GPR_N - 1 - i)));
    end
    r = gpr_read('0, '0);
    r.rd_exp = exp_fixed;
    add_row("r0_reads_zero", r);
    r = gpr_write(5'd5, next_rand());
    r.raddr0 = 5'd5; // No bypass, so the old value comes back.
    add_row("read_during_write", r);
    add_row("read_after_write", gpr_read(5'd5, 5'd3));
    a = next_rand();
    b = next_rand();
    r = gpr_write(5'd7, a);
    r.wen1 = 1'b1;
    r.waddr1 = 5'd7;
    r.wdata1 = b;
    add_row("same_target", r);
    r = gpr_read(5'd7, '0);
    r.rd_exp = exp_fixed;
    r.exp_rd0 = a;
    add_row("port0_wins", r);
    a = next_rand();
    b = next_rand();
    r = gpr_write(5'd9, a);
    r.wen1 = 1'b1;
    r.waddr1 = 5'd10;
    r.wdata1 = b;
    add_row("two_targets", r);
    r = gpr_read(5'd9, 5'd10);
    r.rd_exp = exp_fixed;
    r.exp_rd0 = a;
    r.exp_rd1 = b;
    add_row("both_stored", r);
    a = next_rand();
    r = gpr_write(5'd12, a);
    r.stall = 1'b1;
    r.raddr0 = 5'd1;
    r.raddr1 = 5'd2;
    r.craddr = regs_pkg::creg_pend;
    add_row("stall_write", r);
    r = gpr_read(5'd12, 5'd12);
    r.stall = 1'b1;
    r.craddr = regs_pkg::creg_mask;
    add_row("stall_hold", r);
    r = gpr_read(5'd12, '0);
    r.rd_exp = exp_fixed;
    r.exp_rd0 = a;
    add_row("write_landed", r);
    r = creg_read(regs_pkg::creg_tlb);
    r.exc = 1'b1;
    r.epc = next_rand();
    r.efg = next_rand();
    r.tlb_addr = next_rand();
    add_row("exc_no_tlb", r);
    add_row("read_epc", creg_read(regs_pkg::creg_epc));
    add_row("read_efg", creg_read(regs_pkg::creg_efg));
    r = creg_read(regs_pkg::creg_tlb);
    r.cr_exp = exp_fixed;
    add_row("tlb_not_captured", r);
    r.exc = 1'b1;
    r.tlb_exc = 1'b1;
    r.cr_exp = exp_model;
    r.epc = next_rand();
    r.efg = next_rand();
    r.tlb_addr = next_rand();
    add_row("exc_tlb", r);
    add_row("read_tlb", creg_read(regs_pkg::creg_tlb));
    r = creg_read(regs_pkg::creg_epc);
    r.stall = 1'b1;
    r.exc = 1'b1;
    r.epc = next_rand();
    add_row("exc_stalled", r);
    add_row("epc_kept", creg_read(regs_pkg::creg_epc));
    r = idle_row();
    r.interrupts = 16'h0120;
    add_row("irq_pulse_a", r);
    r.interrupts = 16'h0008;
    add_row("irq_pulse_b", r);
    r = creg_read(regs_pkg::creg_pend);
    r.cr_exp = exp_fixed;
    r.exp_cr = 32'h0000_0128;
    add_row("read_pend", r);
    add_row("mask_no_enable", creg_write(regs_pkg::creg_mask, 32'h0000_0120));
    add_row("mask_enable", creg_write(regs_pkg::creg_mask, 32'h8000_0120));
    add_row("read_mask", creg_read(regs_pkg::creg_mask));
    add_row("clear_pend", creg_write(regs_pkg::creg_pend, '0));
    a = next_rand();
    add_row("cdv_kernel", creg_write(regs_pkg::creg_cdv, a));
    add_row("leave_kernel", creg_write(regs_pkg::creg_mode, '0));
    r = creg_write(regs_pkg::creg_cdv, next_rand());
    r.craddr = regs_pkg::creg_cdv;
    add_row("user_write", r);
    r = creg_read(regs_pkg::creg_cdv);
    r.cr_exp = exp_fixed;
    r.exp_cr = a;
    add_row("write_refused", r);
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // The watchdog is sized from the table once it is built.
  initial begin
    wait (table_built === 1'b1);
    #((rows.size() + 20) * CLK_PERIOD);
    abort_run("The run timed out before every table row was applied.");
  end

  initial begin
    table_built = 1'b0;
    rng_state = 32'd92;
    gpr_known = '{default: 1'b0};
    m_cr = '{default: '0};
    m_cr[regs_pkg::creg_mode] = regs_pkg::word_t'(1);
    m_rd0 = '0;
    m_rd1 = '0;
    m_crd = '0;
    rst_n = 1'b0;
    drive_row(idle_row());
    build_table();
    table_built = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    // Read ports and flags still hold their reset values here.
    check_word("reset_values", "rdata0", '0, rdata0);
    check_word("reset_values", "rdata1", '0, rdata1);
    check_word("reset_values", "crdata", '0, crdata);
    check_bit("reset_values", "kmode", 1'b1, kmode);
    check_bit("reset_values", "irq_valid", 1'b0, irq_valid);
    check_bit("reset_values", "priv_violation", 1'b0, priv_violation);
    rst_n = 1'b1;
    foreach (rows[i]) begin
      drive_row(rows[i]);
      @(posedge clk);
      model_step(rows[i]);
      #1; // Sample halfway between the rising and the next falling edge.
      check_row(i);
      @(negedge clk);
    end
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
regs_pkg.sv
regs_if.sv
write_arbiter.sv
gpr_file.sv
creg_file.sv
irq_status.sv
regs_top.sv
regs_tb_assertions.sv
regs_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the register block testbench with Verilator and runs it.
# The script exits nonzero when the build fails or the simulation stops on $fatal.
verilator --binary --timing --assert --top-module regs_tb -f build.f -o regs_sim \
  && ./obj_dir/regs_sim \
  || { echo "Register block simulation did not complete successfully."; exit 1; }
